// File: common/arm_dp_pkg.sv
`default_nettype none

package arm_dp_pkg;

  // arm data-processing opcodes, instruction bits 24:21
  typedef enum logic [3:0] {
    OP_AND = 4'h0, OP_EOR = 4'h1, OP_SUB = 4'h2, OP_RSB = 4'h3,
    OP_ADD = 4'h4, OP_ADC = 4'h5, OP_SBC = 4'h6, OP_RSC = 4'h7,
    OP_TST = 4'h8, OP_TEQ = 4'h9, OP_CMP = 4'ha, OP_CMN = 4'hb,
    OP_ORR = 4'hc, OP_MOV = 4'hd, OP_BIC = 4'he, OP_MVN = 4'hf
  } dp_opcode_e;

  typedef enum logic [1:0] {
    FN_AND = 2'd0,
    FN_OR  = 2'd1,
    FN_XOR = 2'd2,
    FN_ADD = 2'd3
  } alu_fn_e;

  // same order as the four-input carry mux of the alu
  typedef enum logic [1:0] {
    CIN_ZERO  = 2'd0,
    CIN_ONE   = 2'd1,
    CIN_NOT_C = 2'd2,
    CIN_C     = 2'd3
  } carry_sel_e;

  typedef struct packed {
    logic [3:0] cond;          // ignored, every op executes
    logic [1:0] zero_bits;     // must be 2'b00 for data processing
    logic       i;             // 1: immediate operand 2
    dp_opcode_e opcode;
    logic       s;             // set flags
    logic [3:0] rn;
    logic [3:0] rd;
    logic [3:0] rot;           // rotate right by 2*rot
    logic [7:0] imm8;
  } dp_imm_t;

  typedef struct packed {
    logic [3:0] cond;
    logic [1:0] zero_bits;
    logic       i;
    dp_opcode_e opcode;
    logic       s;
    logic [3:0] rn;
    logic [3:0] rd;
    logic [7:0] shift;         // no barrel shifter here
    logic [3:0] rm;
  } dp_reg_t;

  typedef union packed {
    dp_imm_t imm;
    dp_reg_t rgs;
  } dp_inst_u;

  // decoded operation word, lsb first
  localparam int OP_A_LSB    = 0;
  localparam int OP_B_LSB    = 32;
  localparam int OP_RD_LSB   = 64;
  localparam int OP_CLR_A    = 68;   // alu_decode control block starts here
  localparam int OP_CLR_B    = 69;
  localparam int OP_INV_A    = 70;
  localparam int OP_INV_B    = 71;
  localparam int OP_CSEL_LSB = 72;
  localparam int OP_FN_LSB   = 74;
  localparam int OP_LOGIC    = 76;   // last bit of control block
  localparam int OP_SETF     = 77;
  localparam int OP_WRD      = 78;
  localparam int OP_SHC      = 79;
  localparam int OP_KEEPC    = 80;
  localparam int OP_W        = 81;
  localparam int CTL_W       = 9;    // bits 76:68

  localparam int FLAG_N = 3;
  localparam int FLAG_Z = 2;
  localparam int FLAG_C = 1;
  localparam int FLAG_V = 0;

  // returns {logic_op, fn, carry_sel, invert_b, invert_a, clear_b, clear_a}
  function automatic logic [CTL_W-1:0] alu_decode(input dp_opcode_e opcode);
    logic       clr_a;
    logic       clr_b;
    logic       inv_a;
    logic       inv_b;
    logic       lop;
    carry_sel_e csel;
    alu_fn_e    fn;
    clr_a = 1'b0;
    clr_b = 1'b0;
    inv_a = 1'b0;
    inv_b = 1'b0;
    lop   = 1'b1;                      // most opcodes are logic
    csel  = CIN_ZERO;
    fn    = FN_ADD;
    unique case (opcode)
      OP_AND, OP_TST: fn = FN_AND;
      OP_EOR, OP_TEQ: fn = FN_XOR;
      OP_ORR:         fn = FN_OR;
      OP_MOV: begin clr_a = 1'b1; fn = FN_OR; end                 // 0 | b
      OP_MVN: begin clr_a = 1'b1; inv_b = 1'b1; fn = FN_OR; end   // 0 | ~b
      OP_BIC: begin inv_b = 1'b1; fn = FN_AND; end                // a & ~b
      OP_SUB, OP_CMP: begin inv_b = 1'b1; csel = CIN_ONE; lop = 1'b0; end
      OP_RSB: begin inv_a = 1'b1; csel = CIN_ONE; lop = 1'b0; end
      OP_SBC: begin inv_b = 1'b1; csel = CIN_C; lop = 1'b0; end
      OP_RSC: begin inv_a = 1'b1; csel = CIN_C; lop = 1'b0; end
      OP_ADC: begin csel = CIN_C; lop = 1'b0; end
      default: lop = 1'b0;             // add, cmn
    endcase
    return {lop, fn, csel, inv_b, inv_a, clr_b, clr_a};
  endfunction

endpackage

`default_nettype wire

// File: issue/arm_dp_issue.sv
`timescale 1ns/1ps
`default_nettype none

module arm_dp_issue import arm_dp_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            inst_valid,
  input  dp_inst_u        inst,
  input  logic [31:0]     ra_value,
  input  logic [31:0]     rb_value,
  output logic            inst_ready,
  output logic            push,
  output logic [OP_W-1:0] push_op,
  input  logic            credit_return
);

  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [CNT_W-1:0] credits;     // free buffer slots seen from here
  logic             accept;
  logic [CTL_W-1:0] ctl;
  logic             compare_op;
  logic             set_flags;
  logic             write_rd;
  logic [4:0]       rot_amt;
  logic [63:0]      imm_dbl;
  logic [31:0]      imm_rot;
  logic [31:0]      op2;
  logic             shift_carry;
  logic             keep_c;

  assign inst_ready = (credits != '0);            // room guaranteed downstream
  assign accept     = inst_valid && inst_ready;

  assign ctl        = alu_decode(inst.imm.opcode);  // opcode same in both views
  assign compare_op = inst.imm.opcode inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN};
  assign set_flags  = compare_op || inst.imm.s;     // compares always set flags
  assign write_rd   = !compare_op;                  // compares have no destination

  // rotate right by 2*rot: take the low word of a doubled copy shifted right
  assign rot_amt = {inst.imm.rot, 1'b0};
  assign imm_dbl = {24'd0, inst.imm.imm8, 24'd0, inst.imm.imm8};
  assign imm_rot = imm_dbl[rot_amt +: 32];

  always_comb begin
    if (inst.imm.i) begin
      op2         = imm_rot;
      shift_carry = imm_rot[31];             // rotator carry out
      keep_c      = (inst.imm.rot == 4'd0);  // no rotation leaves c alone
    end else begin
      op2         = rb_value;                // shift field ignored
      shift_carry = 1'b0;
      keep_c      = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= CNT_W'(DEPTH);              // buffer empty after reset
      push    <= 1'b0;
    end else begin
      credits <= credits - CNT_W'(accept) + CNT_W'(credit_return);
      push    <= accept;                     // one cycle after accepting edge
    end
  end

  // operation payload, only meaningful with push
  always_ff @(posedge clk) begin
    if (accept) begin
      push_op <= {keep_c, shift_carry, write_rd, set_flags, ctl,
                  inst.imm.rd, op2, ra_value};
    end
  end

  a_dp_class: assert property (@(posedge clk) disable iff (reset)
    accept |-> inst.imm.zero_bits == 2'b00)
    else $error("accepted word is not a data-processing instruction");

  // holds only while the buffer returns exactly one credit per push
  a_credit_max: assert property (@(posedge clk) disable iff (reset)
    credits <= CNT_W'(DEPTH))
    else $error("credit count above buffer depth");

endmodule

`default_nettype wire

// File: src/op_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module op_buffer import arm_dp_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            push,
  input  logic [OP_W-1:0] push_op,
  output logic            head_valid,
  output logic [OP_W-1:0] head_op,
  input  logic            pop,
  output logic            credit_return
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [OP_W-1:0]  mem [DEPTH];   // operation storage
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;         // occupancy
  logic             full;

  // depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign full       = (count == CNT_W'(DEPTH));
  assign head_valid = (count != '0);     // from registered count
  assign head_op    = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_op;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count         <= count + CNT_W'(push) - CNT_W'(pop);
      credit_return <= pop;              // slot freed, tell issue a cycle later
    end
  end

  // the credit loop in the issue stage must keep a push off a full buffer
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    push |-> !full)
    else $error("push into full operation buffer");

  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    pop |-> head_valid)
    else $error("pop from empty operation buffer");

endmodule

`default_nettype wire

// File: alu/arm_alu_core.sv
`timescale 1ns/1ps
`default_nettype none

module arm_alu_core import arm_dp_pkg::*; (
  input  logic [31:0] op_a,
  input  logic [31:0] op_b,
  input  logic        clear_a,
  input  logic        clear_b,
  input  logic        invert_a,
  input  logic        invert_b,
  input  carry_sel_e  carry_sel,
  input  alu_fn_e     fn,
  input  logic        logic_op,
  input  logic        shift_carry_bit,
  input  logic        keep_c,
  input  logic [3:0]  flags_old,
  output logic [31:0] alu_out,
  output logic [3:0]  flags_new
);

  logic [31:0] a_gated;
  logic [31:0] b_gated;
  logic [31:0] a_cond;
  logic [31:0] b_cond;
  logic        carry_in;
  logic [32:0] sum;
  logic        carry_out;
  logic        ovf;
  logic        zero;

  // operand conditioning: clear first, then invert
  assign a_gated = op_a & {32{~clear_a}};
  assign b_gated = op_b & {32{~clear_b}};
  assign a_cond  = a_gated ^ {32{invert_a}};   // ~a for rsb/rsc
  assign b_cond  = b_gated ^ {32{invert_b}};   // ~b for sub/sbc/bic/mvn

  always_comb begin
    unique case (carry_sel)
      CIN_ZERO:  carry_in = 1'b0;
      CIN_ONE:   carry_in = 1'b1;              // two's complement subtract
      CIN_NOT_C: carry_in = ~flags_old[FLAG_C];
      CIN_C:     carry_in = flags_old[FLAG_C];
      default:   carry_in = 1'b0;
    endcase
  end

  assign sum       = {1'b0, a_cond} + {1'b0, b_cond} + {32'd0, carry_in};
  assign carry_out = sum[32];
  // same-sign inputs, different-sign result
  assign ovf       = (a_cond[31] == b_cond[31]) && (sum[31] != a_cond[31]);

  always_comb begin
    unique case (fn)
      FN_AND:  alu_out = a_cond & b_cond;
      FN_OR:   alu_out = a_cond | b_cond;
      FN_XOR:  alu_out = a_cond ^ b_cond;
      FN_ADD:  alu_out = sum[31:0];
      default: alu_out = sum[31:0];
    endcase
  end

  assign zero = ~|alu_out;                      // zero detect tree

  always_comb begin
    flags_new[FLAG_N] = alu_out[31];
    flags_new[FLAG_Z] = zero;
    if (logic_op) begin
      // logic ops: c from the shifter side, v untouched
      flags_new[FLAG_C] = keep_c ? flags_old[FLAG_C] : shift_carry_bit;
      flags_new[FLAG_V] = flags_old[FLAG_V];
    end else begin
      flags_new[FLAG_C] = carry_out;            // c set means no borrow on sub
      flags_new[FLAG_V] = ovf;
    end
  end

endmodule

`default_nettype wire

// File: alu/arm_dp_execute.sv
`timescale 1ns/1ps
`default_nettype none

module arm_dp_execute import arm_dp_pkg::*; (
  input  logic            clk,
  input  logic            reset,
  input  logic            head_valid,
  input  logic [OP_W-1:0] head_op,
  output logic            pop,
  output logic            result_valid,
  output logic [31:0]     result_data,
  output logic [3:0]      result_rd,
  output logic            result_write,
  output logic [3:0]      result_flags,
  input  logic            result_ready
);

  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [3:0]  rd;
  carry_sel_e  carry_sel;
  alu_fn_e     fn;
  logic        set_flags;
  logic        write_rd;
  logic [31:0] alu_out;
  logic [3:0]  flags_new;
  logic [3:0]  flags_q;        // nzcv

  // operation word fields
  assign op_a      = head_op[OP_A_LSB +: 32];
  assign op_b      = head_op[OP_B_LSB +: 32];
  assign rd        = head_op[OP_RD_LSB +: 4];
  assign carry_sel = carry_sel_e'(head_op[OP_CSEL_LSB +: 2]);
  assign fn        = alu_fn_e'(head_op[OP_FN_LSB +: 2]);
  assign set_flags = head_op[OP_SETF];
  assign write_rd  = head_op[OP_WRD];

  // take the head when the result slot is empty or leaving this cycle
  assign pop = head_valid && (!result_valid || result_ready);

  arm_alu_core u_alu (
    .op_a            (op_a),
    .op_b            (op_b),
    .clear_a         (head_op[OP_CLR_A]),
    .clear_b         (head_op[OP_CLR_B]),
    .invert_a        (head_op[OP_INV_A]),
    .invert_b        (head_op[OP_INV_B]),
    .carry_sel       (carry_sel),
    .fn              (fn),
    .logic_op        (head_op[OP_LOGIC]),
    .shift_carry_bit (head_op[OP_SHC]),
    .keep_c          (head_op[OP_KEEPC]),
    .flags_old       (flags_q),
    .alu_out         (alu_out),
    .flags_new       (flags_new)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
      flags_q      <= 4'b0000;
    end else if (pop) begin
      result_valid <= 1'b1;
      if (set_flags) begin
        flags_q <= flags_new;           // next adc/sbc/rsc sees this
      end
    end else if (result_ready) begin
      result_valid <= 1'b0;             // slot drained, nothing new
    end
  end

  // result record payload
  always_ff @(posedge clk) begin
    if (pop) begin
      result_data  <= alu_out;
      result_rd    <= rd;
      result_write <= write_rd;
    end
  end

  // flags only move on pop, so they travel with the result
  assign result_flags = flags_q;

  a_hold_result: assert property (@(posedge clk) disable iff (reset)
    result_valid && !result_ready |=> result_valid && $stable(result_data))
    else $error("result changed while stalled");

endmodule

`default_nettype wire

// File: src/arm_dp_top.sv
`timescale 1ns/1ps
`default_nettype none

module arm_dp_top import arm_dp_pkg::*; #(
  parameter int DEPTH = 4      // operation buffer slots, 2 or more
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        inst_valid,
  input  dp_inst_u    inst,
  input  logic [31:0] ra_value,
  input  logic [31:0] rb_value,
  output logic        inst_ready,
  output logic        result_valid,
  output logic [31:0] result_data,
  output logic [3:0]  result_rd,
  output logic        result_write,
  output logic [3:0]  result_flags,
  input  logic        result_ready
);

  logic            push;
  logic [OP_W-1:0] push_op;
  logic            credit_return;
  logic            head_valid;
  logic [OP_W-1:0] head_op;
  logic            pop;

  arm_dp_issue #(.DEPTH(DEPTH)) u_issue (
    .clk           (clk),
    .reset         (reset),
    .inst_valid    (inst_valid),
    .inst          (inst),
    .ra_value      (ra_value),
    .rb_value      (rb_value),
    .inst_ready    (inst_ready),
    .push          (push),
    .push_op       (push_op),
    .credit_return (credit_return)
  );

  op_buffer #(.DEPTH(DEPTH)) u_buffer (
    .clk           (clk),
    .reset         (reset),
    .push          (push),
    .push_op       (push_op),
    .head_valid    (head_valid),
    .head_op       (head_op),
    .pop           (pop),
    .credit_return (credit_return)
  );

  arm_dp_execute u_execute (
    .clk          (clk),
    .reset        (reset),
    .head_valid   (head_valid),
    .head_op      (head_op),
    .pop          (pop),
    .result_valid (result_valid),
    .result_data  (result_data),
    .result_rd    (result_rd),
    .result_write (result_write),
    .result_flags (result_flags),
    .result_ready (result_ready)
  );

endmodule

`default_nettype wire

// File: testbench/tb_arm_dp_ref.svh
`ifndef TB_ARM_DP_REF_SVH
`define TB_ARM_DP_REF_SVH

// expected record layout: {data[40:9], rd[8:5], write[4], nzcv[3:0]}
logic [3:0] model_flags;   // nzcv, advanced in acceptance order

// arm AddWithCarry, returns {carry, overflow, sum}
function automatic logic [33:0] add_with_carry(input logic [31:0] x, input logic [31:0] y,
                                               input logic cin);
  logic [32:0] usum;
  longint      ssum;
  logic        ovf;
  usum = {1'b0, x} + {1'b0, y} + {32'd0, cin};
  ssum = longint'($signed(x)) + longint'($signed(y)) + longint'(cin);
  ovf  = (ssum != longint'($signed(usum[31:0])));   // signed result out of range
  return {usum[32], ovf, usum[31:0]};
endfunction

function automatic logic [40:0] arm_dp_expect(input logic [31:0] word, input logic [31:0] a,
                                              input logic [31:0] b);
  logic [3:0]  opc;
  logic [4:0]  amt;
  logic [31:0] op2;
  logic [31:0] res;
  logic [33:0] awc;
  logic        c_old;
  logic        shc;
  logic        arith;
  logic        cmp;
  opc   = word[24:21];
  amt   = {word[11:8], 1'b0};                  // rotate right by twice rot
  c_old = model_flags[1];
  op2   = b;                                   // register form, shift field unused
  shc   = c_old;
  if (word[25]) begin
    op2 = {24'd0, word[7:0]};
    if (amt != 5'd0) begin
      op2 = (op2 >> amt) | (op2 << (6'd32 - amt));
      shc = op2[31];                           // shifter carry out
    end
  end
  awc   = '0;
  arith = 1'b1;
  case (opc)
    OP_SUB, OP_CMP: awc = add_with_carry(a, ~op2, 1'b1);
    OP_RSB:         awc = add_with_carry(op2, ~a, 1'b1);
    OP_ADD, OP_CMN: awc = add_with_carry(a, op2, 1'b0);
    OP_ADC:         awc = add_with_carry(a, op2, c_old);
    OP_SBC:         awc = add_with_carry(a, ~op2, c_old);   // a - op2 - !c
    OP_RSC:         awc = add_with_carry(op2, ~a, c_old);
    default:        arith = 1'b0;
  endcase
  case (opc)
    OP_AND, OP_TST: res = a & op2;
    OP_EOR, OP_TEQ: res = a ^ op2;
    OP_ORR:         res = a | op2;
    OP_MOV:         res = op2;
    OP_BIC:         res = a & ~op2;
    OP_MVN:         res = ~op2;
    default:        res = awc[31:0];
  endcase
  cmp = opc inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN};
  if (word[20] || cmp) begin
    model_flags = {res[31], res == 32'd0, arith ? awc[33] : shc,
                   arith ? awc[32] : model_flags[0]};   // logic ops keep v
  end
  return {res, word[15:12], !cmp, model_flags};
endfunction

`endif

// File: testbench/tb_arm_dp.sv
`timescale 1ns/1ps
`default_nettype none

module tb_arm_dp import arm_dp_pkg::*; ();

  localparam int DEPTH      = 4;
  localparam int N_DIRECTED = 23;
  localparam int N_RANDOM   = 120;
  localparam int N_STALLED  = 24;                // two bursts of 12
  localparam int N_INST     = N_DIRECTED + N_RANDOM + N_STALLED;
  localparam int TIMEOUT_NS = (N_INST * 20 + 8) * 8;

  logic        clk = 1'b0;
  logic        reset;
  logic        inst_valid;
  logic [31:0] inst;
  logic [31:0] ra_value;
  logic [31:0] rb_value;
  logic        inst_ready;
  logic        result_valid;
  logic [31:0] result_data;
  logic [3:0]  result_rd;
  logic        result_write;
  logic [3:0]  result_flags;
  logic        result_ready;
  integer      seed;
  logic [31:0] ready_roll;
  logic        stall;                            // hold result_ready low
  logic        saw_full;                         // inst_ready fell during a stall
  int          mismatches;
  int          failures;
  logic [40:0] exp_q[$];
  logic [40:0] exp_rec;

  `include "tb_arm_dp_ref.svh"

  arm_dp_top #(.DEPTH(DEPTH)) dut (.*);

  always #4 clk = ~clk;

  always @(posedge clk) ready_roll <= $random(seed);   // new ready pattern each cycle

  always @(negedge clk) begin
    result_ready = !stall && (ready_roll[1:0] != 2'b00);   // ready 3 cycles in 4
    if (stall && !inst_ready) begin
      saw_full = 1'b1;
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      mismatches++;
    end
  endtask

  function automatic logic [31:0] encode_dp(input logic i, input dp_opcode_e opc, input logic s,
                                            input logic [3:0] rd, input logic [11:0] op2);
    return {4'he, 2'b00, i, opc, s, 4'h0, rd, op2};   // cond al, rn unused
  endfunction

  task automatic send(input logic [31:0] word, input logic [31:0] a, input logic [31:0] b);
    inst_valid = 1'b1;
    inst       = word;
    ra_value   = a;
    rb_value   = b;
    while (!inst_ready) begin
      @(negedge clk);
    end
    exp_q.push_back(arm_dp_expect(word, a, b));   // accepted on the coming edge
    @(negedge clk);
  endtask

  task automatic idle(input int cycles);
    inst_valid = 1'b0;
    repeat (cycles) @(negedge clk);
  endtask

  task automatic random_inst(output logic [31:0] word, output logic [31:0] a,
                             output logic [31:0] b);
    word        = $random(seed);
    word[27:26] = 2'b00;
    a           = $random(seed);
    b           = $random(seed);
    if (word[3:0] == 4'h0) begin
      a = 32'h7fffffff;                          // lean on overflow corners
    end
  endtask

  task automatic stall_burst(input int cycles, input int count);
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    fork
      begin
        @(posedge clk);
        stall = 1'b1;
        repeat (cycles) @(posedge clk);
        stall = 1'b0;
      end
      repeat (count) begin
        random_inst(w, a, b);
        send(w, a, b);
      end
    join
    idle(1);
  endtask

  // compare on every result transfer
  always @(posedge clk) begin
    if (!reset && result_valid && result_ready) begin
      if (exp_q.size() == 0) begin
        $display("result at %0t ns arrived with no instruction outstanding", $time);
        failures++;
      end else begin
        exp_rec = exp_q.pop_front();
        check_value("result_data", result_data, exp_rec[40:9]);
        check_value("result_rd", 32'(result_rd), 32'(exp_rec[8:5]));
        check_value("result_write", 32'(result_write), 32'(exp_rec[4]));
        check_value("result_flags", 32'(result_flags), 32'(exp_rec[3:0]));
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    failures++;
    $display("timeout after %0d ns, results stopped arriving", TIMEOUT_NS);
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    logic [31:0] word;
    logic [31:0] a;
    logic [31:0] b;
    seed         = 32'h162a;
    reset        = 1'b1;
    inst_valid   = 1'b0;
    inst         = '0;
    ra_value     = '0;
    rb_value     = '0;
    result_ready = 1'b0;
    stall        = 1'b0;
    saw_full     = 1'b0;
    model_flags  = 4'b0000;
    mismatches   = 0;
    failures     = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    check_value("inst_ready", 32'(inst_ready), 32'd1);
    check_value("result_valid", 32'(result_valid), 32'd0);
    check_value("result_flags", 32'(result_flags), 32'd0);
    // arithmetic corners and carry chains
    send(encode_dp(1'b0, OP_ADD, 1'b1, 4'd1, 12'h000), 32'h7fffffff, 32'd1);
    send(encode_dp(1'b0, OP_SUB, 1'b1, 4'd2, 12'h000), 32'd0, 32'd1);
    send(encode_dp(1'b0, OP_SUB, 1'b1, 4'd3, 12'h000), 32'd5, 32'd5);
    send(encode_dp(1'b0, OP_ADD, 1'b1, 4'd4, 12'h000), 32'hffffffff, 32'd1);
    send(encode_dp(1'b0, OP_ADC, 1'b1, 4'd5, 12'h000), 32'd10, 32'd20);
    send(encode_dp(1'b0, OP_SUB, 1'b1, 4'd6, 12'h000), 32'd1, 32'd2);
    send(encode_dp(1'b0, OP_SBC, 1'b1, 4'd7, 12'h000), 32'd100, 32'd3);
    send(encode_dp(1'b0, OP_RSC, 1'b1, 4'd8, 12'h000), 32'd7, 32'd50);
    // logic ops with rotated and plain immediates
    send(encode_dp(1'b1, OP_MOV, 1'b1, 4'd9, 12'h4ff), 32'd0, 32'd0);
    send(encode_dp(1'b1, OP_AND, 1'b1, 4'd10, 12'h0f0), 32'h123456f8, 32'd0);
    send(encode_dp(1'b0, OP_EOR, 1'b1, 4'd11, 12'h000), 32'hff00ff00, 32'h0ff00ff0);
    send(encode_dp(1'b1, OP_ORR, 1'b1, 4'd12, 12'h1f0), 32'd1, 32'd0);   // rotated bit 31 clear
    send(encode_dp(1'b0, OP_BIC, 1'b1, 4'd13, 12'h000), 32'hffffffff, 32'h0000ffff);
    send(encode_dp(1'b1, OP_MVN, 1'b1, 4'd14, 12'h000), 32'd0, 32'd0);
    // compares write nothing and s clear keeps the flags
    send(encode_dp(1'b0, OP_TST, 1'b1, 4'd0, 12'h000), 32'hf0, 32'h0f);
    send(encode_dp(1'b0, OP_TEQ, 1'b1, 4'd0, 12'h000), 32'h80000000, 32'd1);
    send(encode_dp(1'b0, OP_CMP, 1'b1, 4'd0, 12'h000), 32'd3, 32'd9);
    send(encode_dp(1'b0, OP_CMN, 1'b1, 4'd0, 12'h000), 32'hfffffffe, 32'd2);
    send(encode_dp(1'b0, OP_CMP, 1'b0, 4'd0, 12'h000), 32'd9, 32'd10);
    send(encode_dp(1'b0, OP_ADD, 1'b0, 4'd2, 12'h000), 32'hffffffff, 32'hffffffff);
    send(encode_dp(1'b0, OP_ADC, 1'b0, 4'd3, 12'h000), 32'd1, 32'd1);
    // same opcode with immediate then register operand 2
    send(encode_dp(1'b1, OP_ADD, 1'b1, 4'd1, 12'hf12), 32'd1, 32'hdeadbeef);
    send(encode_dp(1'b0, OP_ADD, 1'b1, 4'd1, 12'h000), 32'd1, 32'h48);
    idle(4);
    for (int n = 0; n < N_RANDOM; n++) begin
      random_inst(word, a, b);
      send(word, a, b);
      if (word[31]) begin
        idle(int'(word[30:28]));                 // random gap between issues
      end
    end
    stall_burst(60, 12);
    stall_burst(45, 12);
    for (int k = 0; k < 200 && exp_q.size() != 0; k++) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);                   // catch any extra result
    if (!saw_full) begin
      $display("inst_ready never fell while results were held back");
      failures++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected results never arrived", exp_q.size());
      failures++;
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+testbench
common/arm_dp_pkg.sv
issue/arm_dp_issue.sv
src/op_buffer.sv
alu/arm_alu_core.sv
alu/arm_dp_execute.sv
src/arm_dp_top.sv
testbench/tb_arm_dp.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_arm_dp
FILELIST = filelist.f
OBJDIR   = obj_dir
PASS_MSG = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
